// File: rtl/rv_decoder_params.svh
// Build-wide macros; RV_M_EXT_EN must be 0 or 1 and RV_ILEN must stay 32 for RV32
`ifndef RV_DECODER_PARAMS_SVH
`define RV_DECODER_PARAMS_SVH

// M extension present
//   1 = mul/div decoded by the M sub-decoder
//   0 = those encodings decode as illegal
`define RV_M_EXT_EN 1

// Instruction word width, uncompressed form only
`define RV_ILEN 32

// Compressed words arrive already expanded, so
// only the illegal_c flag from IF is seen here

`endif

// File: rtl/rv_decoder_pkg.sv
// Control word carries no PC or register indices; the enum widths below fix the pipe struct sizes
`include "rv_decoder_params.svh"

package rv_decoder_pkg;

  //////////////////////
  // Encodings
  //////////////////////

  typedef enum logic [6:0] {
    OPC_LOAD     = 7'h03,
    OPC_MISC_MEM = 7'h0f,           // FENCE, FENCE.I
    OPC_OP_IMM   = 7'h13,
    OPC_AUIPC    = 7'h17,
    OPC_STORE    = 7'h23,
    OPC_OP       = 7'h33,           // Shared by RV32I and RV32M
    OPC_LUI      = 7'h37,
    OPC_BRANCH   = 7'h63,
    OPC_JALR     = 7'h67,
    OPC_JAL      = 7'h6f,
    OPC_SYSTEM   = 7'h73            // Only privileged forms, CSR is illegal
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU  // Branch compares
  } alu_opcode_e;

  typedef enum logic       {MUL_MUL, MUL_MULH} mul_opcode_e;  // Low or high product half
  typedef enum logic [1:0] {DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU} div_opcode_e;
  typedef enum logic [1:0] {OP_A_REGFILE, OP_A_PC, OP_A_ZERO} op_a_mux_e;
  typedef enum logic       {OP_B_REGFILE, OP_B_IMM} op_b_mux_e;
  typedef enum logic [2:0] {IMMB_I, IMMB_S, IMMB_B, IMMB_U, IMMB_J, IMMB_PCINCR} imm_b_mux_e;
  typedef enum logic [1:0] {LSU_BYTE, LSU_HALF, LSU_WORD} lsu_size_e;  // Matches funct3[1:0]
  typedef enum logic [2:0] {
    SYS_NONE, SYS_ECALL, SYS_EBREAK, SYS_MRET, SYS_WFI, SYS_FENCE_I
  } sys_opcode_e;

  //////////////////////
  // Control word
  //////////////////////

  typedef struct packed {
    logic        illegal_insn;
    logic        alu_en;
    logic        alu_bch;            // ALU does the branch compare
    logic        alu_jmp;            // JAL or JALR, ALU forms the link address
    logic        alu_jmpr;           // JALR only
    alu_opcode_e alu_operator;
    op_a_mux_e   op_a_mux_sel;
    op_b_mux_e   op_b_mux_sel;
    imm_b_mux_e  imm_b_mux_sel;
    logic        mul_en;
    mul_opcode_e mul_operator;
    logic [1:0]  mul_signed_mode;    // Bit 1 rs2 signed, bit 0 rs1 signed
    logic        div_en;
    div_opcode_e div_operator;
    logic        lsu_en;
    logic        lsu_we;
    lsu_size_e   lsu_size;
    logic        lsu_sext;
    logic        rf_we;
    logic [1:0]  rf_re;              // Bit 1 rs2, bit 0 rs1
    logic        sys_en;
    sys_opcode_e sys_op;
  } decoder_ctrl_t;

  // Illegal word, all enables off and every select on its first value
  parameter decoder_ctrl_t DECODER_CTRL_ILLEGAL = '{
    illegal_insn: 1'b1, alu_en: 1'b0, alu_bch: 1'b0, alu_jmp: 1'b0, alu_jmpr: 1'b0,
    alu_operator: ALU_ADD, op_a_mux_sel: OP_A_REGFILE, op_b_mux_sel: OP_B_REGFILE,
    imm_b_mux_sel: IMMB_I, mul_en: 1'b0, mul_operator: MUL_MUL, mul_signed_mode: 2'b00,
    div_en: 1'b0, div_operator: DIV_DIV, lsu_en: 1'b0, lsu_we: 1'b0, lsu_size: LSU_BYTE,
    lsu_sext: 1'b0, rf_we: 1'b0, rf_re: 2'b00, sys_en: 1'b0, sys_op: SYS_NONE
  };

  //////////////////////
  // Pipe registers
  //////////////////////

  typedef struct packed {
    logic                valid;
    logic                illegal_c_insn;  // Bad compressed form, flagged by IF
    logic [`RV_ILEN-1:0] instr;
  } if_id_pipe_t;

  typedef struct packed {
    logic          valid;
    decoder_ctrl_t ctrl;
  } id_ex_pipe_t;

endpackage

// File: rtl/rv_i_decoder.sv
// Pure combinational; CSR, reserved funct and unknown opcodes give the illegal word, FENCE is a no-op
`timescale 1ns/1ns
`include "rv_decoder_params.svh"

module rv_i_decoder (
  input  logic [`RV_ILEN-1:0]           instr_i,        // Instruction word
  output rv_decoder_pkg::decoder_ctrl_t decoder_ctrl_o  // Full control word or illegal word
);
  import rv_decoder_pkg::*;

  opcode_e       opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  logic          illegal;                                 // Set by any reserved encoding
  decoder_ctrl_t ctrl;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    ctrl              = DECODER_CTRL_ILLEGAL;
    ctrl.illegal_insn = 1'b0;                             // Start from an inactive legal word
    illegal           = 1'b0;

    case (opcode)
      //////////////////////
      // Upper immediates and jumps
      OPC_LUI, OPC_AUIPC: begin
        ctrl.alu_en        = 1'b1;
        ctrl.op_a_mux_sel  = (opcode == OPC_LUI) ? OP_A_ZERO : OP_A_PC;
        ctrl.op_b_mux_sel  = OP_B_IMM;
        ctrl.imm_b_mux_sel = IMMB_U;
        ctrl.rf_we         = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        ctrl.alu_en        = 1'b1;
        ctrl.alu_jmp       = 1'b1;
        ctrl.alu_jmpr      = (opcode == OPC_JALR);
        ctrl.op_a_mux_sel  = OP_A_PC;                     // Link = PC + 4
        ctrl.op_b_mux_sel  = OP_B_IMM;
        ctrl.imm_b_mux_sel = IMMB_PCINCR;
        ctrl.rf_we         = 1'b1;
        ctrl.rf_re         = (opcode == OPC_JALR) ? 2'b01 : 2'b00;  // JALR reads rs1 for target
        illegal            = (opcode == OPC_JALR) && (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        ctrl.alu_en        = 1'b1;
        ctrl.alu_bch       = 1'b1;
        ctrl.imm_b_mux_sel = IMMB_B;
        ctrl.rf_re         = 2'b11;
        case (funct3)
          3'b000:  ctrl.alu_operator = ALU_EQ;
          3'b001:  ctrl.alu_operator = ALU_NE;
          3'b100:  ctrl.alu_operator = ALU_LT;
          3'b101:  ctrl.alu_operator = ALU_GE;
          3'b110:  ctrl.alu_operator = ALU_LTU;
          3'b111:  ctrl.alu_operator = ALU_GEU;
          default: illegal = 1'b1;                        // 010, 011 reserved
        endcase
      end
      //////////////////////
      // Loads and stores
      OPC_LOAD: begin
        ctrl.lsu_en        = 1'b1;
        ctrl.op_b_mux_sel  = OP_B_IMM;                    // Address = rs1 + imm
        ctrl.lsu_size      = lsu_size_e'(funct3[1:0]);
        ctrl.lsu_sext      = ~funct3[2];                  // LBU/LHU zero extend
        ctrl.rf_we         = 1'b1;
        ctrl.rf_re         = 2'b01;
        illegal            = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end
      OPC_STORE: begin
        ctrl.lsu_en        = 1'b1;
        ctrl.lsu_we        = 1'b1;
        ctrl.op_b_mux_sel  = OP_B_IMM;
        ctrl.imm_b_mux_sel = IMMB_S;
        ctrl.lsu_size      = lsu_size_e'(funct3[1:0]);
        ctrl.rf_re         = 2'b11;                       // rs1 base, rs2 data
        illegal            = funct3[2] || (funct3[1:0] == 2'b11);
      end
      //////////////////////
      // Register and immediate ALU ops
      OPC_OP_IMM, OPC_OP: begin
        ctrl.alu_en        = 1'b1;
        ctrl.op_b_mux_sel  = (opcode == OPC_OP) ? OP_B_REGFILE : OP_B_IMM;
        ctrl.rf_we         = 1'b1;
        ctrl.rf_re         = (opcode == OPC_OP) ? 2'b11 : 2'b01;
        case (funct3)
          3'b000: ctrl.alu_operator = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
          3'b001: ctrl.alu_operator = ALU_SLL;
          3'b010: ctrl.alu_operator = ALU_SLT;
          3'b011: ctrl.alu_operator = ALU_SLTU;
          3'b100: ctrl.alu_operator = ALU_XOR;
          3'b101: ctrl.alu_operator = funct7[5] ? ALU_SRA : ALU_SRL;
          3'b110: ctrl.alu_operator = ALU_OR;
          default: ctrl.alu_operator = ALU_AND;
        endcase
        if (opcode == OPC_OP) begin
          // Only funct7 0x00 everywhere, 0x20 on ADD/SRL slots; 0x01 belongs to M
          illegal = (funct7 != 7'h00) &&
                    !((funct7 == 7'h20) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
        end else if (funct3 == 3'b001) begin
          illegal = (funct7 != 7'h00);                    // SLLI shamt[5] must be 0
        end else if (funct3 == 3'b101) begin
          illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
        end
      end
      //////////////////////
      // Fences and privileged ops
      OPC_MISC_MEM: begin
        if (funct3 == 3'b001) begin
          ctrl.sys_en = 1'b1;
          ctrl.sys_op = SYS_FENCE_I;
        end else begin
          illegal = (funct3 != 3'b000);                   // FENCE stays an inactive legal word
        end
      end
      OPC_SYSTEM: begin
        ctrl.sys_en = 1'b1;
        illegal     = (funct3 != 3'b000) || (instr_i[19:7] != '0);  // CSR forms land here
        case (instr_i[31:20])
          12'h000: ctrl.sys_op = SYS_ECALL;
          12'h001: ctrl.sys_op = SYS_EBREAK;
          12'h302: ctrl.sys_op = SYS_MRET;
          12'h105: ctrl.sys_op = SYS_WFI;
          default: illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase

    if (illegal) begin
      ctrl = DECODER_CTRL_ILLEGAL;
    end
  end

  assign decoder_ctrl_o = ctrl;

endmodule

// File: rtl/rv_m_decoder.sv
// Pure combinational; only OP with funct7 0x01 is matched, everything else is the illegal word
`timescale 1ns/1ns
`include "rv_decoder_params.svh"

module rv_m_decoder (
  input  logic [`RV_ILEN-1:0]           instr_i,        // Instruction word
  output rv_decoder_pkg::decoder_ctrl_t decoder_ctrl_o  // Mul/div word or illegal word
);
  import rv_decoder_pkg::*;

  logic [2:0] funct3;
  logic       match;                                      // OP opcode with funct7 = 0x01

  assign funct3 = instr_i[14:12];
  assign match  = (instr_i[6:0] == OPC_OP) && (instr_i[31:25] == 7'h01);

  always_comb begin
    decoder_ctrl_o = DECODER_CTRL_ILLEGAL;
    if (match) begin
      decoder_ctrl_o.illegal_insn = 1'b0;
      decoder_ctrl_o.rf_we        = 1'b1;
      decoder_ctrl_o.rf_re        = 2'b11;
      if (!funct3[2]) begin
        decoder_ctrl_o.mul_en       = 1'b1;
        decoder_ctrl_o.mul_operator = (funct3 == 3'b000) ? MUL_MUL : MUL_MULH;
        case (funct3[1:0])
          2'b00:   decoder_ctrl_o.mul_signed_mode = 2'b11;  // MUL
          2'b01:   decoder_ctrl_o.mul_signed_mode = 2'b11;  // MULH
          2'b10:   decoder_ctrl_o.mul_signed_mode = 2'b01;  // MULHSU, rs1 signed only
          default: decoder_ctrl_o.mul_signed_mode = 2'b00;  // MULHU
        endcase
      end else begin
        decoder_ctrl_o.div_en       = 1'b1;
        decoder_ctrl_o.div_operator = div_opcode_e'(funct3[1:0]);  // DIV, DIVU, REM, REMU
      end
    end
  end

endmodule

// File: rtl/rv_decoder.sv
// Combinational merge; M presence comes from RV_M_EXT_EN, illegal_c and deassert act on the merged word
`timescale 1ns/1ns
`include "rv_decoder_params.svh"

module rv_decoder (
  input  logic [`RV_ILEN-1:0]           instr_i,           // Instruction word
  input  logic                          illegal_c_insn_i,  // Compressed form was illegal
  input  logic                          deassert_we_i,     // Controller kills side effects
  output rv_decoder_pkg::decoder_ctrl_t ctrl_o
);
  import rv_decoder_pkg::*;

  decoder_ctrl_t i_ctrl;
  decoder_ctrl_t m_ctrl;
  decoder_ctrl_t sub_ctrl;                                // Priority pick
  decoder_ctrl_t merged;                                  // After owner fields and illegal_c

  rv_i_decoder i_decoder_i (
    .instr_i        (instr_i),
    .decoder_ctrl_o (i_ctrl)
  );

  if (`RV_M_EXT_EN) begin : gen_m_decoder
    rv_m_decoder m_decoder_i (
      .instr_i        (instr_i),
      .decoder_ctrl_o (m_ctrl)
    );
  end else begin : gen_no_m_decoder
    assign m_ctrl = DECODER_CTRL_ILLEGAL;                 // Mul/div encodings fall to illegal
  end

  //////////////////////
  // Merge
  always_comb begin
    if (!m_ctrl.illegal_insn) begin
      sub_ctrl = m_ctrl;                                  // M first
    end else if (!i_ctrl.illegal_insn) begin
      sub_ctrl = i_ctrl;
    end else begin
      sub_ctrl = DECODER_CTRL_ILLEGAL;
    end

    merged                 = sub_ctrl;
    merged.alu_bch         = i_ctrl.alu_bch;              // Control flow and sys owned by I
    merged.alu_jmp         = i_ctrl.alu_jmp;
    merged.alu_jmpr        = i_ctrl.alu_jmpr;
    merged.sys_en          = i_ctrl.sys_en;
    merged.sys_op          = i_ctrl.sys_op;
    merged.mul_en          = m_ctrl.mul_en;               // Mul/div owned by M
    merged.mul_operator    = m_ctrl.mul_operator;
    merged.mul_signed_mode = m_ctrl.mul_signed_mode;
    merged.div_en          = m_ctrl.div_en;
    merged.div_operator    = m_ctrl.div_operator;
    if (illegal_c_insn_i) begin
      merged = DECODER_CTRL_ILLEGAL;
    end
  end

  // Suppression keeps operators and selects, drops enables
  always_comb begin
    ctrl_o = merged;
    if (deassert_we_i) begin
      ctrl_o.alu_en       = 1'b0;
      ctrl_o.mul_en       = 1'b0;
      ctrl_o.div_en       = 1'b0;
      ctrl_o.lsu_en       = 1'b0;
      ctrl_o.rf_we        = 1'b0;
      ctrl_o.sys_en       = 1'b0;
      ctrl_o.illegal_insn = 1'b0;
    end
  end

  // Encoding spaces of the two sub-decoders are disjoint
  a_one_match: assert final (m_ctrl.illegal_insn || i_ctrl.illegal_insn);

endmodule

// File: rtl/rv_id_ex_pipe.sv
// Kill beats halt beats capture; ctrl only loads on a valid input, so it keeps stale values otherwise
`timescale 1ns/1ns

module rv_id_ex_pipe (
  input  logic                          clk,
  input  logic                          arst_n_i,
  input  logic                          valid_i,       // IF/ID valid
  input  rv_decoder_pkg::decoder_ctrl_t ctrl_i,        // Decoded word
  input  logic                          halt_i,        // Back-pressure from EX
  input  logic                          kill_i,        // Flush
  output rv_decoder_pkg::id_ex_pipe_t   id_ex_pipe_o
);
  import rv_decoder_pkg::*;

  id_ex_pipe_t pipe_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pipe_q.valid             <= 1'b0;
      pipe_q.ctrl              <= DECODER_CTRL_ILLEGAL;
      pipe_q.ctrl.illegal_insn <= 1'b0;                   // Nothing enabled out of reset
    end else if (kill_i) begin
      pipe_q.valid <= 1'b0;                               // ctrl left as is
    end else if (!halt_i) begin
      pipe_q.valid <= valid_i;
      if (valid_i) begin
        pipe_q.ctrl <= ctrl_i;
      end
    end
  end

  assign id_ex_pipe_o = pipe_q;

  // Halt without kill freezes the whole stage output
  a_halt_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    halt_i && !kill_i |=> $stable(id_ex_pipe_o));

  // Flushed slot is empty next cycle
  a_kill_empty: assert property (@(posedge clk) disable iff (!arst_n_i)
    kill_i |=> !id_ex_pipe_o.valid);

endmodule

// File: rtl/rv_id_stage.sv
// ID stage top; decode is same-cycle, result registered once, no handshake beyond plain levels
`timescale 1ns/1ns

module rv_id_stage (
  input  logic                        clk,
  input  logic                        arst_n_i,
  input  rv_decoder_pkg::if_id_pipe_t if_id_pipe_i,   // From IF
  input  logic                        deassert_we_i,  // Controller suppression
  input  logic                        halt_i,         // Hold ID/EX
  input  logic                        kill_i,         // Flush ID/EX
  output rv_decoder_pkg::id_ex_pipe_t id_ex_pipe_o    // To EX
);
  import rv_decoder_pkg::*;

  decoder_ctrl_t dec_ctrl;                              // Decoder to ID/EX

  rv_decoder decoder_i (
    .instr_i          (if_id_pipe_i.instr),
    .illegal_c_insn_i (if_id_pipe_i.illegal_c_insn),
    .deassert_we_i    (deassert_we_i),
    .ctrl_o           (dec_ctrl)
  );

  rv_id_ex_pipe id_ex_pipe_i (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .valid_i      (if_id_pipe_i.valid),
    .ctrl_i       (dec_ctrl),
    .halt_i       (halt_i),
    .kill_i       (kill_i),
    .id_ex_pipe_o (id_ex_pipe_o)
  );

endmodule

// File: verif/rv_id_checker.sv
// Reference mirrors RV_M_EXT_EN from the params header; outputs are compared on the falling edge only
`timescale 1ns/1ns
`include "rv_decoder_params.svh"

module rv_id_checker (
  input  logic                        clk,
  input  logic                        arst_n_i,
  input  rv_decoder_pkg::if_id_pipe_t if_id_pipe_i,   // DUT inputs, observed
  input  logic                        deassert_we_i,
  input  logic                        halt_i,
  input  logic                        kill_i,
  input  rv_decoder_pkg::id_ex_pipe_t id_ex_pipe_i,   // DUT output under test
  output int                          error_count_o,
  output int                          check_count_o
);
  import rv_decoder_pkg::*;

  id_ex_pipe_t exp_q;                                   // Expected ID/EX contents

  //////////////////////
  // Reference decode
  function automatic decoder_ctrl_t ref_decode(input logic [`RV_ILEN-1:0] w,
                                               input logic ill_c, input logic deassert);
    decoder_ctrl_t c;
    logic          ok;
    logic [2:0]    f3;
    logic [6:0]    f7;
    f3             = w[14:12];
    f7             = w[31:25];
    c              = DECODER_CTRL_ILLEGAL;
    c.illegal_insn = 1'b0;                              // Inactive legal word as a base
    ok             = 1'b1;
    if (w[6:0] == OPC_OP && f7 == 7'h01) begin          // M space
      ok      = (`RV_M_EXT_EN != 0);
      c.rf_we = 1'b1;
      c.rf_re = 2'b11;
      if (!f3[2]) begin
        c.mul_en          = 1'b1;
        c.mul_operator    = (f3[1:0] == 2'b00) ? MUL_MUL : MUL_MULH;
        c.mul_signed_mode = {~f3[1], ~(f3[1] & f3[0])};  // rs2 signed on MUL/MULH, rs1 unless MULHU
      end else begin
        c.div_en       = 1'b1;
        c.div_operator = div_opcode_e'(f3[1:0]);
      end
    end else begin
      case (w[6:0])
        OPC_LUI, OPC_AUIPC: begin
          c.alu_en        = 1'b1;
          c.op_a_mux_sel  = (w[6:0] == OPC_LUI) ? OP_A_ZERO : OP_A_PC;
          c.op_b_mux_sel  = OP_B_IMM;
          c.imm_b_mux_sel = IMMB_U;
          c.rf_we         = 1'b1;
        end
        OPC_JAL, OPC_JALR: begin
          c.alu_en        = 1'b1;
          c.alu_jmp       = 1'b1;
          c.alu_jmpr      = (w[6:0] == OPC_JALR);
          c.op_a_mux_sel  = OP_A_PC;                    // Link address
          c.op_b_mux_sel  = OP_B_IMM;
          c.imm_b_mux_sel = IMMB_PCINCR;
          c.rf_we         = 1'b1;
          c.rf_re         = {1'b0, c.alu_jmpr};
          ok              = !c.alu_jmpr || (f3 == 3'b000);
        end
        OPC_BRANCH: begin
          c.alu_en        = 1'b1;
          c.alu_bch       = 1'b1;
          c.imm_b_mux_sel = IMMB_B;
          c.rf_re         = 2'b11;
          c.alu_operator  = f3[2] ? alu_opcode_e'(ALU_LT + f3[1:0]) : alu_opcode_e'(ALU_EQ + f3[0]);
          ok              = (f3[2:1] != 2'b01);
        end
        OPC_LOAD, OPC_STORE: begin
          c.lsu_en       = 1'b1;
          c.lsu_we       = (w[6:0] == OPC_STORE);
          c.op_b_mux_sel = OP_B_IMM;
          c.lsu_size     = lsu_size_e'(f3[1:0]);
          c.rf_re        = c.lsu_we ? 2'b11 : 2'b01;
          c.rf_we        = !c.lsu_we;
          c.lsu_sext     = !c.lsu_we && !f3[2];         // Signed loads only
          if (c.lsu_we) begin
            c.imm_b_mux_sel = IMMB_S;
          end
          ok = (f3[1:0] != 2'b11) && (c.lsu_we ? !f3[2] : (f3 != 3'b110));
        end
        OPC_OP, OPC_OP_IMM: begin
          c.alu_en       = 1'b1;
          c.rf_we        = 1'b1;
          c.op_b_mux_sel = (w[6:0] == OPC_OP) ? OP_B_REGFILE : OP_B_IMM;
          c.rf_re        = (w[6:0] == OPC_OP) ? 2'b11 : 2'b01;
          case (f3)
            3'b000:  c.alu_operator = (w[6:0] == OPC_OP && f7 == 7'h20) ? ALU_SUB : ALU_ADD;
            3'b001:  c.alu_operator = ALU_SLL;
            3'b010:  c.alu_operator = ALU_SLT;
            3'b011:  c.alu_operator = ALU_SLTU;
            3'b100:  c.alu_operator = ALU_XOR;
            3'b101:  c.alu_operator = (f7 == 7'h20) ? ALU_SRA : ALU_SRL;
            3'b110:  c.alu_operator = ALU_OR;
            default: c.alu_operator = ALU_AND;
          endcase
          if (w[6:0] == OPC_OP) begin
            ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
          end else if (f3 == 3'b001) begin
            ok = (f7 == 7'h00);
          end else if (f3 == 3'b101) begin
            ok = (f7 == 7'h00) || (f7 == 7'h20);
          end
        end
        OPC_MISC_MEM: begin
          ok = (f3 == 3'b000) || (f3 == 3'b001);        // FENCE has no controls
          if (f3 == 3'b001) begin
            c.sys_en = 1'b1;
            c.sys_op = SYS_FENCE_I;
          end
        end
        OPC_SYSTEM: begin
          c.sys_en = 1'b1;
          ok       = (f3 == 3'b000) && (w[19:15] == 5'd0) && (w[11:7] == 5'd0);
          case (w[31:20])
            12'h000: c.sys_op = SYS_ECALL;
            12'h001: c.sys_op = SYS_EBREAK;
            12'h302: c.sys_op = SYS_MRET;
            12'h105: c.sys_op = SYS_WFI;
            default: ok = 1'b0;                         // CSR space and the rest
          endcase
        end
        default: ok = 1'b0;
      endcase
    end
    if (!ok || ill_c) begin
      c = DECODER_CTRL_ILLEGAL;
    end
    if (deassert) begin                                 // Selects survive, enables drop
      c.alu_en       = 1'b0;
      c.mul_en       = 1'b0;
      c.div_en       = 1'b0;
      c.lsu_en       = 1'b0;
      c.rf_we        = 1'b0;
      c.sys_en       = 1'b0;
      c.illegal_insn = 1'b0;
    end
    return c;
  endfunction

  task automatic check_field(input string name, input logic [7:0] got, input logic [7:0] exp_v);
    if (got !== exp_v) begin
      error_count_o = error_count_o + 1;
      $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, name, got, exp_v);
    end
  endtask

  initial begin
    error_count_o = 0;
    check_count_o = 0;
  end

  //////////////////////
  // Expected ID/EX register, kill then halt then capture
  always @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exp_q.valid             <= 1'b0;
      exp_q.ctrl              <= DECODER_CTRL_ILLEGAL;
      exp_q.ctrl.illegal_insn <= 1'b0;                  // Idle word out of reset
    end else if (kill_i) begin
      exp_q.valid <= 1'b0;
    end else if (!halt_i) begin
      exp_q.valid <= if_id_pipe_i.valid;
      if (if_id_pipe_i.valid) begin
        exp_q.ctrl <= ref_decode(if_id_pipe_i.instr, if_id_pipe_i.illegal_c_insn, deassert_we_i);
      end
    end
  end

  // Field by field so a mismatch names its field
  always @(negedge clk) begin
    decoder_ctrl_t g;
    decoder_ctrl_t e;
    g = id_ex_pipe_i.ctrl;
    e = exp_q.ctrl;
    if (arst_n_i === 1'b1) begin                        // Reset state checked from release on
      check_count_o = check_count_o + 1;
      check_field("valid", id_ex_pipe_i.valid, exp_q.valid);
      check_field("illegal_insn", g.illegal_insn, e.illegal_insn);
      check_field("alu_en", g.alu_en, e.alu_en);
      check_field("alu_bch", g.alu_bch, e.alu_bch);
      check_field("alu_jmp", g.alu_jmp, e.alu_jmp);
      check_field("alu_jmpr", g.alu_jmpr, e.alu_jmpr);
      check_field("alu_operator", g.alu_operator, e.alu_operator);
      check_field("op_a_mux_sel", g.op_a_mux_sel, e.op_a_mux_sel);
      check_field("op_b_mux_sel", g.op_b_mux_sel, e.op_b_mux_sel);
      check_field("imm_b_mux_sel", g.imm_b_mux_sel, e.imm_b_mux_sel);
      check_field("mul_en", g.mul_en, e.mul_en);
      check_field("mul_operator", g.mul_operator, e.mul_operator);
      check_field("mul_signed_mode", g.mul_signed_mode, e.mul_signed_mode);
      check_field("div_en", g.div_en, e.div_en);
      check_field("div_operator", g.div_operator, e.div_operator);
      check_field("lsu_en", g.lsu_en, e.lsu_en);
      check_field("lsu_we", g.lsu_we, e.lsu_we);
      check_field("lsu_size", g.lsu_size, e.lsu_size);
      check_field("lsu_sext", g.lsu_sext, e.lsu_sext);
      check_field("rf_we", g.rf_we, e.rf_we);
      check_field("rf_re", g.rf_re, e.rf_re);
      check_field("sys_en", g.sys_en, e.sys_en);
      check_field("sys_op", g.sys_op, e.sys_op);
    end
  end

endmodule

// File: verif/tb_rv_id_stage.sv
// Fixed seed and run length; directed words first, then random mix with halt, kill and deassert
`timescale 1ns/1ns

module tb_rv_id_stage;
  import rv_decoder_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 16;
  localparam int N_INSN     = 2000;
  localparam int N_DIR      = 14;
  localparam int TIMEOUT_NS = (N_INSN + RST_CYCLES) * 2 * CLK_PERIOD;

  logic        clk;
  logic        arst_n;
  if_id_pipe_t if_id_pipe;
  logic        deassert_we;
  logic        halt;
  logic        kill;
  id_ex_pipe_t id_ex_pipe;
  int          error_count;
  int          check_count;
  int          seed = 87095;

  logic [6:0]  opc_tab [11] = '{OPC_LOAD, OPC_MISC_MEM, OPC_OP_IMM, OPC_AUIPC, OPC_STORE,
                                OPC_OP, OPC_LUI, OPC_BRANCH, OPC_JALR, OPC_JAL, OPC_SYSTEM};
  logic [11:0] sys_imm [4]  = '{12'h000, 12'h001, 12'h302, 12'h105};  // ECALL EBREAK MRET WFI
  logic [31:0] directed [N_DIR] = '{
    32'h00000073,                                       // ECALL
    32'h00100073,                                       // EBREAK
    32'h30200073,                                       // MRET
    32'h10500073,                                       // WFI
    32'h0000100f,                                       // FENCE.I
    32'h0ff0000f,                                       // FENCE
    32'h30001073,                                       // CSRRW, illegal here
    32'h402080b3,                                       // SUB
    32'h4030d093,                                       // SRAI
    32'h0220a0b3,                                       // MULHSU
    32'h0220f0b3,                                       // REMU
    32'h00006003,                                       // Load funct3 110, reserved
    32'h00001067,                                       // JALR funct3 001, reserved
    32'h00000000                                        // All zero
  };

  rv_id_stage dut_i (
    .clk           (clk),
    .arst_n_i      (arst_n),
    .if_id_pipe_i  (if_id_pipe),
    .deassert_we_i (deassert_we),
    .halt_i        (halt),
    .kill_i        (kill),
    .id_ex_pipe_o  (id_ex_pipe)
  );

  rv_id_checker checker_i (
    .clk           (clk),
    .arst_n_i      (arst_n),
    .if_id_pipe_i  (if_id_pipe),
    .deassert_we_i (deassert_we),
    .halt_i        (halt),
    .kill_i        (kill),
    .id_ex_pipe_i  (id_ex_pipe),
    .error_count_o (error_count),
    .check_count_o (check_count)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////
  // Stimulus
  task automatic gen_word(output logic [31:0] w);
    int pick;
    int f7sel;
    w     = $random(seed);
    pick  = {$random(seed)} % 16;
    f7sel = {$random(seed)} % 4;
    if (pick < 11) begin                                // Known opcode, random fields
      w[6:0] = opc_tab[pick];
      if (w[6:0] == OPC_OP || w[6:0] == OPC_OP_IMM) begin
        case (f7sel)
          0:       w[31:25] = 7'h00;
          1:       w[31:25] = 7'h20;
          2:       w[31:25] = 7'h01;                    // M space
          default: ;                                    // Random funct7, mostly reserved
        endcase
      end else if (w[6:0] == OPC_SYSTEM && f7sel != 3) begin
        w[31:7] = {sys_imm[{$random(seed)} % 4], 13'h0};
      end else if (w[6:0] == OPC_JALR && f7sel != 3) begin
        w[14:12] = 3'b000;
      end
    end else if (pick < 13) begin
      w = directed[{$random(seed)} % N_DIR];
    end                                                 // Else a raw random word
  endtask

  task automatic drive_next(input int n);
    logic [31:0] w;
    gen_word(w);
    if_id_pipe.instr          = (n < N_DIR) ? directed[n] : w;
    if_id_pipe.valid          = ({$random(seed)} % 8) != 0;
    if_id_pipe.illegal_c_insn = ({$random(seed)} % 20) == 0;
    deassert_we               = ({$random(seed)} % 10) == 0;
    halt                      = ({$random(seed)} % 8) == 0;
    kill                      = ({$random(seed)} % 16) == 0;
    if (n < N_DIR) begin                                // Directed words pass clean
      if_id_pipe.valid          = 1'b1;
      if_id_pipe.illegal_c_insn = 1'b0;
      {deassert_we, halt, kill} = 3'b000;
    end
  endtask

  initial begin
    arst_n      = 1'b0;
    if_id_pipe  = '0;
    deassert_we = 1'b0;
    halt        = 1'b0;
    kill        = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    for (int n = 0; n < N_INSN; n++) begin
      @(negedge clk);
      drive_next(n);
    end
    @(negedge clk);
    if_id_pipe                = '0;                     // Drain
    {deassert_we, halt, kill} = 3'b000;
    repeat (3) @(negedge clk);
    @(posedge clk);
    $display("Checked %0d cycles, %0d errors", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: stimulus did not finish within %0d ns", TIMEOUT_NS);
    $display("Something failed");
    $finish;
  end

endmodule

// File: compile.f
+incdir+rtl
rtl/rv_decoder_pkg.sv
rtl/rv_i_decoder.sv
rtl/rv_m_decoder.sv
rtl/rv_decoder.sv
rtl/rv_id_ex_pipe.sv
rtl/rv_id_stage.sv
verif/rv_id_checker.sv
verif/tb_rv_id_stage.sv

// File: Bender.yml
package:
  name: rv_id_stage

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rv_decoder_pkg.sv
      - rtl/rv_i_decoder.sv
      - rtl/rv_m_decoder.sv
      - rtl/rv_decoder.sv
      - rtl/rv_id_ex_pipe.sv
      - rtl/rv_id_stage.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/rv_id_checker.sv
      - verif/tb_rv_id_stage.sv
